/* flow_arb_core.sv */
// Combinational handshake core; assumes the base arbiter always grants on any request
`timescale 1ns/1ps
`default_nettype none

module flow_arb_core (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire flow_arb_pkg::flow_vec_t can_grant,
  input  wire flow_arb_pkg::flow_vec_t grant,
  input  wire flow_arb_pkg::flow_vec_t push_valid,
  input  wire logic                   pop_ready,
  output flow_arb_pkg::flow_vec_t     request,
  output logic                        enable_priority_update,
  output flow_arb_pkg::flow_vec_t     push_ready,
  output logic                        pop_valid
);

  import flow_arb_pkg::*;

  // --------------------------------------------------------------------------
  // Handshake mapping
  // --------------------------------------------------------------------------

  // Every valid flow competes
  assign request = push_valid;

  // Pointer may only move when the pop side takes the item
  assign enable_priority_update = pop_ready;

  // Only the would-be winner is ready, and only without back-pressure
  assign push_ready = {num_flows{pop_ready}} & can_grant;

  // Arbiter always grants, so any valid flow gives a pop item
  // (may drop if the source withdraws, as pop_valid is unstable)
  assign pop_valid = |push_valid;

  // --------------------------------------------------------------------------
  // Protocol checks
  // --------------------------------------------------------------------------

  // At most one flow transfers per cycle
  push_handshake_onehot0_a: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(push_valid & push_ready)
  );

  no_push_ready_without_pop_ready_a: assert property (
    @(posedge clk) disable iff (!rst_n) (|push_ready) |-> pop_ready
  );

  // Push and pop transfers happen in the same cycle
  push_handshake_implies_pop_handshake_a: assert property (
    @(posedge clk) disable iff (!rst_n)
      (|(push_valid & push_ready)) |-> (pop_valid && pop_ready)
  );

  // Arbiter view must agree with the mask the core relies on
  grant_is_request_and_can_grant_a: assert property (
    @(posedge clk) disable iff (!rst_n) grant == (request & can_grant)
  );

  for (genvar i = 0; i < num_flows; i++) begin : gen_flow_checks
    // Accepted only when the arbiter picked this flow
    only_accept_on_grant_a: assert property (
      @(posedge clk) disable iff (!rst_n)
        (push_valid[i] && push_ready[i]) |-> grant[i]
    );

    // Source keeps valid up until it is taken
    push_valid_stable_a: assert property (
      @(posedge clk) disable iff (!rst_n)
        (push_valid[i] && !push_ready[i]) |=> push_valid[i]
    );
  end

endmodule : flow_arb_core

`default_nettype wire

/* flow_arb_pkg.sv */
// Widths are fixed here; num_flows must equal 2**flow_idx_width for the index wrap to hold
`default_nettype none

package flow_arb_pkg;

  // --------------------------------------------------------------------------
  // Flow geometry
  // --------------------------------------------------------------------------

  // Number of push flows merged onto the pop stream
  localparam int num_flows = 4;

  // Payload bits carried by each flow
  localparam int data_width = 8;

  // Bits needed to name one flow
  localparam int flow_idx_width = 2;

  // --------------------------------------------------------------------------
  // Shared vector types
  // --------------------------------------------------------------------------

  // One bit per flow: valid, ready, request, can_grant, grant
  typedef logic [num_flows-1:0] flow_vec_t;

  // A single payload word
  typedef logic [data_width-1:0] flow_data_t;

  // All push payloads side by side, flow 0 in the low bits
  typedef logic [num_flows*data_width-1:0] flow_bus_t;

  // Flow number, as shown on pop_flow
  typedef logic [flow_idx_width-1:0] flow_idx_t;

endpackage : flow_arb_pkg

`default_nettype wire

/* flow_arb_rr.f */
flow_arb_pkg.sv
rr_arb.sv
flow_arb_core.sv
flow_data_mux.sv
flow_arb_rr.sv
tb_flow_arb_rr.sv

/* flow_arb_rr.sv */
// Zero-latency 4-flow round-robin merge; pop_valid and pop data follow push_valid unregistered
`timescale 1ns/1ps
`default_nettype none

module flow_arb_rr (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  // Push side, one ready/valid pair per flow
  input  wire flow_arb_pkg::flow_vec_t push_valid,
  input  wire flow_arb_pkg::flow_bus_t push_data,
  output flow_arb_pkg::flow_vec_t     push_ready,
  // Pop side
  input  wire logic                   pop_ready,
  output logic                        pop_valid,
  output flow_arb_pkg::flow_data_t    pop_data,
  output flow_arb_pkg::flow_idx_t     pop_flow
);

  import flow_arb_pkg::*;

  // --------------------------------------------------------------------------
  // Core to arbiter wiring
  // --------------------------------------------------------------------------

  flow_vec_t request;
  flow_vec_t can_grant;
  flow_vec_t grant;
  logic      enable_priority_update;

  // Handshake gating
  flow_arb_core flow_arb_core_inst (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .can_grant              (can_grant),
    .grant                  (grant),
    .push_valid             (push_valid),
    .pop_ready              (pop_ready),
    .request                (request),
    .enable_priority_update (enable_priority_update),
    .push_ready             (push_ready),
    .pop_valid              (pop_valid)
  );

  // Round-robin pick, the only state in the design
  rr_arb rr_arb_inst (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .request                (request),
    .enable_priority_update (enable_priority_update),
    .can_grant              (can_grant),
    .grant                  (grant)
  );

  // Payload and index of the winner
  flow_data_mux flow_data_mux_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .grant     (grant),
    .push_data (push_data),
    .pop_data  (pop_data),
    .pop_flow  (pop_flow)
  );

endmodule : flow_arb_rr

`default_nettype wire

/* flow_data_mux.sv */
// Expects a one-hot or zero grant; with no grant the outputs are index 0 and zero data
`timescale 1ns/1ps
`default_nettype none

module flow_data_mux (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire flow_arb_pkg::flow_vec_t grant,
  input  wire flow_arb_pkg::flow_bus_t push_data,
  output flow_arb_pkg::flow_data_t    pop_data,
  output flow_arb_pkg::flow_idx_t     pop_flow
);

  import flow_arb_pkg::*;

  // --------------------------------------------------------------------------
  // Grant encoding
  // --------------------------------------------------------------------------

  // Index of the granted flow
  flow_idx_t sel_idx;
  // Payload slice picked by the index
  flow_data_t sel_data;

  // OR of the set bit positions, valid for one-hot grant
  always_comb begin
    sel_idx = '0;
    for (int i = 0; i < num_flows; i++) begin
      if (grant[i]) begin
        sel_idx = sel_idx | flow_idx_t'(i);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Payload select
  // --------------------------------------------------------------------------

  assign sel_data = push_data[sel_idx*data_width +: data_width];

  // Zero data when nothing is granted
  assign pop_data = (|grant) ? sel_data : '0;
  assign pop_flow = sel_idx;

  // Encoder is only correct for a single set bit
  grant_onehot0_a: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(grant)
  );

endmodule : flow_data_mux

`default_nettype wire

/* rr_arb.sv */
// Always grants when any request is set; pointer moves only on an enabled, granted cycle
`timescale 1ns/1ps
`default_nettype none

module rr_arb (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire flow_arb_pkg::flow_vec_t request,
  input  wire logic                   enable_priority_update,
  output flow_arb_pkg::flow_vec_t     can_grant,
  output flow_arb_pkg::flow_vec_t     grant
);

  import flow_arb_pkg::*;

  // --------------------------------------------------------------------------
  // Priority state
  // --------------------------------------------------------------------------

  // Flow that has highest priority this cycle
  flow_idx_t ptr;
  // Flow just past the winner, wraps at num_flows
  flow_idx_t next_ptr;

  // --------------------------------------------------------------------------
  // Rotating first-one search
  // --------------------------------------------------------------------------

  // Winning flow and whether any request was seen
  flow_idx_t win_idx;
  logic      found;
  // Flow being looked at in the scan
  flow_idx_t scan_idx;

  always_comb begin
    win_idx  = '0;
    found    = 1'b0;
    scan_idx = ptr;
    // Walk upward from the pointer, wrapping around
    for (int k = 0; k < num_flows; k++) begin
      scan_idx = flow_idx_t'((int'(ptr) + k) % num_flows);
      if (!found && request[scan_idx]) begin
        found   = 1'b1;
        win_idx = scan_idx;
      end
    end
  end

  // One-hot winner, zero when nothing requests
  always_comb begin
    can_grant = '0;
    if (found) begin
      can_grant[win_idx] = 1'b1;
    end
  end

  // Same as can_grant since the search only lands on requesters
  assign grant = can_grant & request;

  // Next highest priority goes to the flow after the winner
  assign next_ptr = (win_idx == flow_idx_t'(num_flows - 1)) ? '0 : win_idx + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (enable_priority_update && (|grant)) begin
      ptr <= next_ptr;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  grant_onehot0_a: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(grant)
  );

  // Work-conserving: a pending request is always served
  request_implies_grant_a: assert property (
    @(posedge clk) disable iff (!rst_n) (|request) |-> (|grant)
  );

endmodule : rr_arb

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the flow_arb_rr testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_flow_arb_rr \
  -f flow_arb_rr.f -o sim_flow_arb_rr > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_flow_arb_rr > sim.log 2>&1 ; cat sim.log

! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

/* tb_flow_arb_rr.sv */
// Table rows assume one row per clock cycle and a pointer that starts at flow 0 after reset
`timescale 1ns/1ps
`default_nettype none

module tb_flow_arb_rr;

  import flow_arb_pkg::*;

  // --------------------------------------------------------------------------
  // Clock, reset and DUT
  // --------------------------------------------------------------------------

  localparam int num_rows    = 23;
  localparam int reset_cycles = 16;
  // Reset, four cycles per row worst case, plus slack
  localparam int cycle_limit = reset_cycles + 4 * num_rows + 20;

  logic       clk;
  logic       rst_n;
  flow_vec_t  push_valid;
  flow_bus_t  push_data;
  logic       pop_ready;
  flow_vec_t  push_ready;
  logic       pop_valid;
  flow_data_t pop_data;
  flow_idx_t  pop_flow;

  flow_arb_rr flow_arb_rr_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_flow   (pop_flow)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Stimulus and expected value table
  // --------------------------------------------------------------------------

  flow_vec_t  row_valid     [num_rows];
  logic       row_pop_ready [num_rows];
  flow_data_t row_base      [num_rows];
  flow_vec_t  exp_ready     [num_rows];
  logic       exp_valid     [num_rows];
  flow_idx_t  exp_flow      [num_rows];
  flow_data_t exp_data      [num_rows];

  int row_errors;
  int pass_rows;
  int fail_rows;
  int cycle_count;

  task automatic set_row(input int r, input flow_vec_t pv, input logic pr,
                         input flow_data_t base, input flow_vec_t e_ready,
                         input logic e_valid, input flow_idx_t e_flow,
                         input flow_data_t e_data);
    row_valid[r]     = pv;
    row_pop_ready[r] = pr;
    row_base[r]      = base;
    exp_ready[r]     = e_ready;
    exp_valid[r]     = e_valid;
    exp_flow[r]      = e_flow;
    exp_data[r]      = e_data;
  endtask

  // Expected values follow the round-robin rule, pointer noted per row
  task automatic load_table;
    // Idle, pop_ready does not matter
    set_row(0,  4'b0000, 1'b1, 8'h00, 4'b0000, 1'b0, 2'd0, 8'h00);
    set_row(1,  4'b0000, 1'b0, 8'h08, 4'b0000, 1'b0, 2'd0, 8'h00);
    // All valid, ptr 0 so flow 0 wins first
    set_row(2,  4'b1111, 1'b1, 8'h10, 4'b0001, 1'b1, 2'd0, 8'h10);
    // Rotation 1, 2, 3, 0
    set_row(3,  4'b1111, 1'b1, 8'h18, 4'b0010, 1'b1, 2'd1, 8'h19);
    set_row(4,  4'b1111, 1'b1, 8'h20, 4'b0100, 1'b1, 2'd2, 8'h22);
    set_row(5,  4'b1111, 1'b1, 8'h28, 4'b1000, 1'b1, 2'd3, 8'h2B);
    set_row(6,  4'b1111, 1'b1, 8'h30, 4'b0001, 1'b1, 2'd0, 8'h30);
    // Back-pressure at ptr 1, then flow 1 taken
    set_row(7,  4'b1111, 1'b0, 8'h38, 4'b0000, 1'b1, 2'd1, 8'h39);
    set_row(8,  4'b1111, 1'b1, 8'h40, 4'b0010, 1'b1, 2'd1, 8'h41);
    // Drain flows 2, 3 and 0
    set_row(9,  4'b1101, 1'b1, 8'h48, 4'b0100, 1'b1, 2'd2, 8'h4A);
    set_row(10, 4'b1001, 1'b1, 8'h50, 4'b1000, 1'b1, 2'd3, 8'h53);
    set_row(11, 4'b0001, 1'b1, 8'h58, 4'b0001, 1'b1, 2'd0, 8'h58);
    set_row(12, 4'b0010, 1'b1, 8'h60, 4'b0010, 1'b1, 2'd1, 8'h61);
    // Sparse 1 and 3 with ptr 2, flow 3 wins
    set_row(13, 4'b1010, 1'b0, 8'h68, 4'b0000, 1'b1, 2'd3, 8'h6B);
    set_row(14, 4'b1010, 1'b1, 8'h70, 4'b1000, 1'b1, 2'd3, 8'h73);
    set_row(15, 4'b0010, 1'b1, 8'h78, 4'b0010, 1'b1, 2'd1, 8'h79);
    // Single flows pass through at any pointer
    set_row(16, 4'b0001, 1'b0, 8'h80, 4'b0000, 1'b1, 2'd0, 8'h80);
    set_row(17, 4'b0001, 1'b1, 8'h88, 4'b0001, 1'b1, 2'd0, 8'h88);
    set_row(18, 4'b0100, 1'b1, 8'h90, 4'b0100, 1'b1, 2'd2, 8'h92);
    set_row(19, 4'b0000, 1'b0, 8'h98, 4'b0000, 1'b0, 2'd0, 8'h00);
    // Ptr 3 wraps to flow 0
    set_row(20, 4'b0011, 1'b1, 8'hA0, 4'b0001, 1'b1, 2'd0, 8'hA0);
    set_row(21, 4'b0010, 1'b1, 8'hA8, 4'b0010, 1'b1, 2'd1, 8'hA9);
    set_row(22, 4'b0000, 1'b1, 8'hB0, 4'b0000, 1'b0, 2'd0, 8'h00);
  endtask

  // Flow i carries base plus i
  function automatic flow_bus_t pack_payloads(input flow_data_t base);
    flow_bus_t bus;
    bus = '0;
    for (int i = 0; i < num_flows; i++) begin
      bus[i*data_width +: data_width] = base + flow_data_t'(i);
    end
    return bus;
  endfunction

  // --------------------------------------------------------------------------
  // Drive and check
  // --------------------------------------------------------------------------

  task automatic apply_row(input int r);
    push_valid <= row_valid[r];
    push_data  <= pack_payloads(row_base[r]);
    pop_ready  <= row_pop_ready[r];
  endtask

  task automatic check_row(input int r);
    row_errors = 0;
    assert (push_ready === exp_ready[r]) else begin
      $display("[ERROR] %0d ns: row %0d push_ready %b, expected %b",
               $time, r, push_ready, exp_ready[r]);
      row_errors++;
    end
    assert (pop_valid === exp_valid[r]) else begin
      $display("[ERROR] %0d ns: row %0d pop_valid %b, expected %b",
               $time, r, pop_valid, exp_valid[r]);
      row_errors++;
    end
    assert (pop_flow === exp_flow[r]) else begin
      $display("[ERROR] %0d ns: row %0d pop_flow %0d, expected %0d",
               $time, r, pop_flow, exp_flow[r]);
      row_errors++;
    end
    assert (pop_data === exp_data[r]) else begin
      $display("[ERROR] %0d ns: row %0d pop_data %h, expected %h",
               $time, r, pop_data, exp_data[r]);
      row_errors++;
    end
    if (row_errors == 0) begin
      pass_rows++;
    end else begin
      fail_rows++;
    end
    $display("row %0d: push_valid %b pop_ready %b -> %s", r, row_valid[r],
             row_pop_ready[r], (row_errors == 0) ? "ok" : "MISMATCH");
  endtask

  initial begin
    rst_n      = 1'b0;
    push_valid = '0;
    push_data  = '0;
    pop_ready  = 1'b0;
    pass_rows  = 0;
    fail_rows  = 0;
    load_table();
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    // One row per cycle, outputs settled by the falling edge
    for (int r = 0; r < num_rows; r++) begin
      @(posedge clk);
      apply_row(r);
      @(negedge clk);
      check_row(r);
    end
    $display("Rows checked: %0d, passed: %0d, failed: %0d", num_rows, pass_rows, fail_rows);
    if (fail_rows == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog on total cycles
  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

endmodule : tb_flow_arb_rr

`default_nettype wire
